// File: Bender.yml
package:
  name: fifo_subsystem

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fifo_pkg.sv
      - rtl/csr_pkg.sv
      - rtl/simple_dual_port_ram.sv
      - rtl/advanced_fifo_controller.sv
      - rtl/valid_ready_advanced_fifo.sv
      - rtl/fifo_csr_wb.sv
      - rtl/fifo_subsystem_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verif/fifo_subsystem_checker.sv
      - verif/fifo_subsystem_tb.sv

// File: list.f
+incdir+rtl
rtl/fifo_pkg.sv
rtl/csr_pkg.sv
rtl/simple_dual_port_ram.sv
rtl/advanced_fifo_controller.sv
rtl/valid_ready_advanced_fifo.sv
rtl/fifo_csr_wb.sv
rtl/fifo_subsystem_top.sv
verif/fifo_subsystem_checker.sv
verif/fifo_subsystem_tb.sv

// File: rtl/advanced_fifo_controller.sv
// FIFO controller: wrapping pointers, level counter, flush and threshold flags
`timescale 1ns/1ps
`default_nettype none

`include "fifo_defs.svh"

module advanced_fifo_controller #(
  parameter int WIDTH = `FIFO_WIDTH,
  parameter int DEPTH = `FIFO_DEPTH
) (
  input  wire logic             clock,
  input  wire logic             arst_n,
  input  wire logic             flush,
  // Gated transfer requests
  input  wire logic             write_enable,
  input  wire logic             read_enable,
  input  wire logic [WIDTH-1:0] write_data,
  // Threshold levels
  input  wire fifo_pkg::level_t lower_threshold_level,
  input  wire fifo_pkg::level_t upper_threshold_level,
  // Status
  output logic                  empty,
  output logic                  full,
  output fifo_pkg::level_t      level,
  output logic                  lower_threshold_status,
  output logic                  upper_threshold_status,
  // RAM side
  output logic                  memory_write_enable,
  output fifo_pkg::addr_t       memory_write_address,
  output logic [WIDTH-1:0]      memory_write_data,
  output fifo_pkg::addr_t       memory_read_address,
  input  wire logic [WIDTH-1:0] memory_read_data,
  // Head of queue
  output logic [WIDTH-1:0]      read_data
);

  // Pointers into the RAM
  fifo_pkg::addr_t write_pointer;
  fifo_pkg::addr_t read_pointer;
  fifo_pkg::addr_t write_pointer_next;
  fifo_pkg::addr_t read_pointer_next;

  // Wrap at last entry
  // Depth need not be a power of two
  assign write_pointer_next = (write_pointer == fifo_pkg::addr_t'(DEPTH - 1)) ?
                              '0 : write_pointer + 1'b1;
  assign read_pointer_next  = (read_pointer == fifo_pkg::addr_t'(DEPTH - 1)) ?
                              '0 : read_pointer + 1'b1;

  // Write pointer, flush wins over a write
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      write_pointer <= '0;
    end else if (flush) begin
      write_pointer <= '0;
    end else if (write_enable) begin
      write_pointer <= write_pointer_next;
    end
  end

  // Read pointer, same priority
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      read_pointer <= '0;
    end else if (flush) begin
      read_pointer <= '0;
    end else if (read_enable) begin
      read_pointer <= read_pointer_next;
    end
  end

  // Occupancy counter
  // Simultaneous read and write leaves it unchanged
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      level <= '0;
    end else if (flush) begin
      level <= '0;
    end else begin
      case ({write_enable, read_enable})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  // Flags straight from the level
  assign empty = (level == '0);
  assign full  = (level == fifo_pkg::level_t'(DEPTH));

  // Threshold compares, both inclusive
  assign lower_threshold_status = (level <= lower_threshold_level);
  assign upper_threshold_status = (level >= upper_threshold_level);

  // RAM write follows the write pointer
  // No store on a flush edge, slot is freed anyway
  assign memory_write_enable  = write_enable & ~flush;
  assign memory_write_address = write_pointer;
  assign memory_write_data    = write_data;

  // Head entry comes straight out of the RAM
  assign memory_read_address = read_pointer;
  assign read_data           = memory_read_data;

endmodule

`default_nettype wire

// File: rtl/csr_pkg.sv
// CSR bus types: Wishbone address and data, bus slave FSM states
`default_nettype none

`include "fifo_defs.svh"

package csr_pkg;

  // Register word index on the bus
  typedef logic [`WB_ADR_W-1:0] wb_adr_t;

  // Bus data word, both directions
  typedef logic [`WB_DAT_W-1:0] wb_dat_t;

  // Slave FSM
  // IDLE waits for a strobe
  // ACK lasts exactly one cycle
  typedef enum logic {
    WB_IDLE = 1'b0,
    WB_ACK  = 1'b1
  } wb_state_t;

endpackage

`default_nettype wire

// File: rtl/fifo_csr_wb.sv
// FIFO CSR block: Wishbone classic slave for thresholds, flush and status
`timescale 1ns/1ps
`default_nettype none

`include "fifo_defs.svh"

module fifo_csr_wb (
  input  wire logic             clock,
  input  wire logic             arst_n,
  // Wishbone slave
  input  wire logic             wb_cyc,
  input  wire logic             wb_stb,
  input  wire logic             wb_we,
  input  wire csr_pkg::wb_adr_t wb_adr,
  input  wire csr_pkg::wb_dat_t wb_dat_w,
  output csr_pkg::wb_dat_t      wb_dat_r,
  output logic                  wb_ack,
  // FIFO control
  output logic                  flush,
  output fifo_pkg::level_t      lower_threshold_level,
  output fifo_pkg::level_t      upper_threshold_level,
  // FIFO status
  input  wire fifo_pkg::level_t level,
  input  wire logic             empty,
  input  wire logic             full,
  input  wire logic             lower_threshold_status,
  input  wire logic             upper_threshold_status
);

  csr_pkg::wb_state_t state;
  csr_pkg::wb_state_t state_next;
  csr_pkg::wb_dat_t   status_word;
  logic               write_strobe;

  // Accept in IDLE, ack for one cycle, back to IDLE
  always_comb begin
    state_next = state;
    case (state)
      csr_pkg::WB_IDLE: begin
        if (wb_cyc && wb_stb) begin
          state_next = csr_pkg::WB_ACK;
        end
      end
      csr_pkg::WB_ACK: begin
        state_next = csr_pkg::WB_IDLE;
      end
      default: begin
        state_next = csr_pkg::WB_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state <= csr_pkg::WB_IDLE;
    end else begin
      state <= state_next;
    end
  end

  assign wb_ack = (state == csr_pkg::WB_ACK);

  // Master holds its signals, so the write lands on the ack edge
  assign write_strobe = wb_ack && wb_we;

  // Flush pulse shares the ack cycle
  assign flush = write_strobe && (wb_adr == csr_pkg::wb_adr_t'(`REG_CTRL)) && wb_dat_w[0];

  // Threshold registers
  // Defaults: lower at 1, upper one below full
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      lower_threshold_level <= fifo_pkg::level_t'(1);
      upper_threshold_level <= fifo_pkg::level_t'(`FIFO_DEPTH - 1);
    end else if (write_strobe) begin
      if (wb_adr == csr_pkg::wb_adr_t'(`REG_LOWER)) begin
        lower_threshold_level <= fifo_pkg::level_t'(wb_dat_w);
      end
      if (wb_adr == csr_pkg::wb_adr_t'(`REG_UPPER)) begin
        upper_threshold_level <= fifo_pkg::level_t'(wb_dat_w);
      end
    end
  end

  // Packed STATUS, level in low bits
  always_comb begin
    status_word                  = csr_pkg::wb_dat_t'(level);
    status_word[`STAT_EMPTY_BIT] = empty;
    status_word[`STAT_FULL_BIT]  = full;
    status_word[`STAT_LOWER_BIT] = lower_threshold_status;
    status_word[`STAT_UPPER_BIT] = upper_threshold_status;
  end

  // Read mux
  // CTRL and unmapped indices read as zero
  always_comb begin
    case (wb_adr)
      csr_pkg::wb_adr_t'(`REG_LOWER):  wb_dat_r = csr_pkg::wb_dat_t'(lower_threshold_level);
      csr_pkg::wb_adr_t'(`REG_UPPER):  wb_dat_r = csr_pkg::wb_dat_t'(upper_threshold_level);
      csr_pkg::wb_adr_t'(`REG_STATUS): wb_dat_r = status_word;
      default:                         wb_dat_r = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/fifo_defs.svh
// FIFO subsystem defines: data path sizes, bus widths and CSR map
`ifndef FIFO_DEFS_SVH
`define FIFO_DEFS_SVH

// Data path sizing
`define FIFO_WIDTH 16
`define FIFO_DEPTH 8
// RAM index width, level is one bit wider
`define FIFO_ADDR_W 3

// Wishbone widths
`define WB_ADR_W 4
`define WB_DAT_W 32

// Register word indices
`define REG_CTRL   0
`define REG_LOWER  1
`define REG_UPPER  2
`define REG_STATUS 3

// STATUS flag positions, level sits in the low bits
`define STAT_EMPTY_BIT 8
`define STAT_FULL_BIT  9
`define STAT_LOWER_BIT 10
`define STAT_UPPER_BIT 11

`endif

// File: rtl/fifo_pkg.sv
// FIFO data path types: data word, RAM index and occupancy level
`default_nettype none

`include "fifo_defs.svh"

package fifo_pkg;

  // One stored word
  typedef logic [`FIFO_WIDTH-1:0] data_t;

  // RAM index, wraps at depth
  typedef logic [`FIFO_ADDR_W-1:0] addr_t;

  // Occupancy 0..depth
  // Extra bit so a full FIFO is distinct from empty
  typedef logic [`FIFO_ADDR_W:0] level_t;

endpackage

`default_nettype wire

// File: rtl/fifo_subsystem_top.sv
// FIFO subsystem top: valid-ready FIFO with its Wishbone CSR block
`timescale 1ns/1ps
`default_nettype none

`include "fifo_defs.svh"

module fifo_subsystem_top (
  input  wire logic             clock,
  input  wire logic             arst_n,
  // Producer side
  input  wire fifo_pkg::data_t  write_data,
  input  wire logic             write_valid,
  output logic                  write_ready,
  // Consumer side
  output fifo_pkg::data_t       read_data,
  output logic                  read_valid,
  input  wire logic             read_ready,
  // Wishbone slave
  input  wire logic             wb_cyc,
  input  wire logic             wb_stb,
  input  wire logic             wb_we,
  input  wire csr_pkg::wb_adr_t wb_adr,
  input  wire csr_pkg::wb_dat_t wb_dat_w,
  output csr_pkg::wb_dat_t      wb_dat_r,
  output logic                  wb_ack
);

  // CSR to FIFO
  logic             flush;
  fifo_pkg::level_t lower_threshold_level;
  fifo_pkg::level_t upper_threshold_level;

  // FIFO to CSR
  logic             full;
  logic             empty;
  fifo_pkg::level_t level;
  logic             lower_threshold_status;
  logic             upper_threshold_status;

  valid_ready_advanced_fifo #(
    .WIDTH (`FIFO_WIDTH),
    .DEPTH (`FIFO_DEPTH)
  ) fifo0 (
    .clock                  (clock),
    .arst_n                 (arst_n),
    .flush                  (flush),
    .full                   (full),
    .empty                  (empty),
    .write_data             (write_data),
    .write_valid            (write_valid),
    .write_ready            (write_ready),
    .read_data              (read_data),
    .read_valid             (read_valid),
    .read_ready             (read_ready),
    .level                  (level),
    .lower_threshold_level  (lower_threshold_level),
    .lower_threshold_status (lower_threshold_status),
    .upper_threshold_level  (upper_threshold_level),
    .upper_threshold_status (upper_threshold_status)
  );

  fifo_csr_wb csr0 (
    .clock                  (clock),
    .arst_n                 (arst_n),
    .wb_cyc                 (wb_cyc),
    .wb_stb                 (wb_stb),
    .wb_we                  (wb_we),
    .wb_adr                 (wb_adr),
    .wb_dat_w               (wb_dat_w),
    .wb_dat_r               (wb_dat_r),
    .wb_ack                 (wb_ack),
    .flush                  (flush),
    .lower_threshold_level  (lower_threshold_level),
    .upper_threshold_level  (upper_threshold_level),
    .level                  (level),
    .empty                  (empty),
    .full                   (full),
    .lower_threshold_status (lower_threshold_status),
    .upper_threshold_status (upper_threshold_status)
  );

endmodule

`default_nettype wire

// File: rtl/simple_dual_port_ram.sv
// Simple dual-port RAM: synchronous write port, combinational read port
`timescale 1ns/1ps
`default_nettype none

`include "fifo_defs.svh"

module simple_dual_port_ram #(
  parameter int WIDTH = `FIFO_WIDTH,
  parameter int DEPTH = `FIFO_DEPTH
) (
  input  wire logic            clock,
  // Write port
  input  wire logic            write_enable,
  input  wire fifo_pkg::addr_t write_address,
  input  wire fifo_pkg::data_t write_data,
  // Read port
  input  wire fifo_pkg::addr_t read_address,
  output fifo_pkg::data_t      read_data
);

  // Storage, contents only meaningful below the controller level
  logic [WIDTH-1:0] memory [DEPTH];

  // Write on the rising edge
  always_ff @(posedge clock) begin
    if (write_enable) begin
      memory[write_address] <= write_data;
    end
  end

  // Asynchronous read, head visible right after the write edge
  assign read_data = memory[read_address];

endmodule

`default_nettype wire

// File: rtl/valid_ready_advanced_fifo.sv
// Valid-ready FIFO: handshake gating around the controller and its RAM
`timescale 1ns/1ps
`default_nettype none

`include "fifo_defs.svh"

module valid_ready_advanced_fifo #(
  parameter int WIDTH = `FIFO_WIDTH,
  parameter int DEPTH = `FIFO_DEPTH
) (
  input  wire logic             clock,
  input  wire logic             arst_n,
  input  wire logic             flush,
  // Flags
  output logic                  full,
  output logic                  empty,
  // Write side
  input  wire fifo_pkg::data_t  write_data,
  input  wire logic             write_valid,
  output logic                  write_ready,
  // Read side
  output fifo_pkg::data_t       read_data,
  output logic                  read_valid,
  input  wire logic             read_ready,
  // Level and thresholds
  output fifo_pkg::level_t      level,
  input  wire fifo_pkg::level_t lower_threshold_level,
  output logic                  lower_threshold_status,
  input  wire fifo_pkg::level_t upper_threshold_level,
  output logic                  upper_threshold_status
);

  // Transfers happen only where valid meets ready
  logic write_enable;
  logic read_enable;

  // RAM connections
  logic            memory_write_enable;
  fifo_pkg::addr_t memory_write_address;
  fifo_pkg::data_t memory_write_data;
  fifo_pkg::addr_t memory_read_address;
  fifo_pkg::data_t memory_read_data;

  // Ready while room left, valid while something stored
  assign write_ready = ~full;
  assign read_valid  = ~empty;

  assign write_enable = write_valid & write_ready;
  assign read_enable  = read_valid & read_ready;

  advanced_fifo_controller #(
    .WIDTH (WIDTH),
    .DEPTH (DEPTH)
  ) controller (
    .clock                  (clock),
    .arst_n                 (arst_n),
    .flush                  (flush),
    .write_enable           (write_enable),
    .read_enable            (read_enable),
    .write_data             (write_data),
    .lower_threshold_level  (lower_threshold_level),
    .upper_threshold_level  (upper_threshold_level),
    .empty                  (empty),
    .full                   (full),
    .level                  (level),
    .lower_threshold_status (lower_threshold_status),
    .upper_threshold_status (upper_threshold_status),
    .memory_write_enable    (memory_write_enable),
    .memory_write_address   (memory_write_address),
    .memory_write_data      (memory_write_data),
    .memory_read_address    (memory_read_address),
    .memory_read_data       (memory_read_data),
    .read_data              (read_data)
  );

  simple_dual_port_ram #(
    .WIDTH (WIDTH),
    .DEPTH (DEPTH)
  ) memory (
    .clock         (clock),
    .write_enable  (memory_write_enable),
    .write_address (memory_write_address),
    .write_data    (memory_write_data),
    .read_address  (memory_read_address),
    .read_data     (memory_read_data)
  );

endmodule

`default_nettype wire

// File: verif/fifo_subsystem_checker.sv
// FIFO subsystem checker: bus and handshake rules as concurrent assertions
`timescale 1ns/1ps
`default_nettype none

`include "fifo_defs.svh"

module fifo_subsystem_checker (
  input wire logic             clock,
  input wire logic             arst_n,
  input wire logic             wb_ack,
  input wire logic             write_ready,
  input wire logic             flush,
  input wire logic             read_valid,
  input wire fifo_pkg::level_t level
);

  // Number of assertion failures so far
  int unsigned failures = 0;

  // Ack is a one-cycle pulse
  ack_single_cycle: assert property (
    @(posedge clock) disable iff (!arst_n) wb_ack |=> !wb_ack
  ) else begin
    $error("wb_ack stayed high for two cycles");
    failures++;
  end

  // No room, no ready, seen from the level counter
  ready_low_when_full: assert property (
    @(posedge clock) disable iff (!arst_n)
      level == fifo_pkg::level_t'(`FIFO_DEPTH) |-> !write_ready
  ) else begin
    $error("write_ready high while the FIFO is full");
    failures++;
  end

  // Flush edge empties the FIFO
  empty_after_flush: assert property (
    @(posedge clock) disable iff (!arst_n) flush |=> !read_valid
  ) else begin
    $error("read_valid still high after a flush edge");
    failures++;
  end

  // Occupancy bound
  level_in_range: assert property (
    @(posedge clock) disable iff (!arst_n) level <= fifo_pkg::level_t'(`FIFO_DEPTH)
  ) else begin
    $error("level above the FIFO depth");
    failures++;
  end

endmodule

bind fifo_subsystem_top fifo_subsystem_checker checker0 (
  .clock       (clock),
  .arst_n      (arst_n),
  .wb_ack      (wb_ack),
  .write_ready (write_ready),
  .flush       (flush),
  .read_valid  (read_valid),
  .level       (level)
);

`default_nettype wire

// File: verif/fifo_subsystem_tb.sv
// FIFO subsystem testbench: directed tests of the valid-ready path and the CSR bus
`timescale 1ns/1ps
`default_nettype none

`include "fifo_defs.svh"

module fifo_subsystem_tb;

  localparam int DEPTH        = `FIFO_DEPTH;
  localparam int CLOCK_PERIOD = 10;
  localparam int ORDER_WORDS  = 64;
  // Words moved by each test, in and out
  localparam int TRANSFER_COUNT  = 2 * (ORDER_WORDS + (DEPTH + 1) + DEPTH + 8);
  localparam int WATCHDOG_CYCLES = TRANSFER_COUNT * 20 + 500;

  logic             clock;
  logic             arst_n;
  fifo_pkg::data_t  write_data;
  logic             write_valid;
  logic             write_ready;
  fifo_pkg::data_t  read_data;
  logic             read_valid;
  logic             read_ready;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  csr_pkg::wb_adr_t wb_adr;
  csr_pkg::wb_dat_t wb_dat_w;
  csr_pkg::wb_dat_t wb_dat_r;
  logic             wb_ack;

  // Reference model: stored words and thresholds last written
  fifo_pkg::data_t  model_q[$];
  fifo_pkg::level_t model_lower;
  fifo_pkg::level_t model_upper;

  int errors = 0;

  fifo_subsystem_top dut0 (
    .clock       (clock),
    .arst_n      (arst_n),
    .write_data  (write_data),
    .write_valid (write_valid),
    .write_ready (write_ready),
    .read_data   (read_data),
    .read_valid  (read_valid),
    .read_ready  (read_ready),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack)
  );

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  task automatic check_data(input string name, input fifo_pkg::data_t expected,
                            input fifo_pkg::data_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s expected 0x%h got 0x%h at %0t", name, expected, actual, $time);
      errors++;
    end
  endtask

  task automatic check_level(input string name, input fifo_pkg::level_t expected,
                             input fifo_pkg::level_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s expected 0x%h got 0x%h at %0t", name, expected, actual, $time);
      errors++;
    end
  endtask

  task automatic check_reg(input string name, input csr_pkg::wb_dat_t expected,
                           input csr_pkg::wb_dat_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s expected 0x%h got 0x%h at %0t", name, expected, actual, $time);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[ERROR] %s expected 0x%h got 0x%h at %0t", name, expected, actual, $time);
      errors++;
    end
  endtask

  // STATUS word as the register map defines it
  function automatic csr_pkg::wb_dat_t expected_status();
    csr_pkg::wb_dat_t word;
    fifo_pkg::level_t lvl;
    lvl  = fifo_pkg::level_t'(model_q.size());
    word = csr_pkg::wb_dat_t'(lvl);
    word[`STAT_EMPTY_BIT] = (lvl == 0);
    word[`STAT_FULL_BIT]  = (lvl == fifo_pkg::level_t'(DEPTH));
    word[`STAT_LOWER_BIT] = (lvl <= model_lower);
    word[`STAT_UPPER_BIT] = (lvl >= model_upper);
    return word;
  endfunction

  // One data path cycle, entered 1 ns after an edge
  task automatic data_cycle(input logic valid, input fifo_pkg::data_t data, input logic ready,
                            output logic write_fire, output logic read_fire);
    write_valid = valid;
    write_data  = data;
    read_ready  = ready;
    // Flags follow the stored level only
    check_flag("read_valid", model_q.size() != 0, read_valid);
    check_flag("write_ready", model_q.size() < DEPTH, write_ready);
    // Expected transfers from the model occupancy
    write_fire = valid && (model_q.size() < DEPTH);
    read_fire  = ready && (model_q.size() != 0);
    // Head shows the oldest word, taken or not
    if (model_q.size() != 0) begin
      check_data("read_data", model_q[0], read_data);
    end
    @(posedge clock);
    #1;
    if (read_fire) begin
      void'(model_q.pop_front());
    end
    if (write_fire) begin
      model_q.push_back(data);
    end
  endtask

  // Offer a word until it is taken
  task automatic push_word(input fifo_pkg::data_t data);
    logic wf;
    logic rf;
    wf = 1'b0;
    while (!wf) begin
      data_cycle(1'b1, data, 1'b0, wf, rf);
    end
  endtask

  task automatic pop_word();
    logic wf;
    logic rf;
    rf = 1'b0;
    while (!rf) begin
      data_cycle(1'b0, '0, 1'b1, wf, rf);
    end
  endtask

  // Classic cycle, held until ack and through the ack edge
  task automatic bus_access(input logic write, input csr_pkg::wb_adr_t adr,
                            input csr_pkg::wb_dat_t wdata, output csr_pkg::wb_dat_t rdata);
    int waited;
    write_valid = 1'b0;
    read_ready  = 1'b0;
    wb_cyc      = 1'b1;
    wb_stb      = 1'b1;
    wb_we       = write;
    wb_adr      = adr;
    wb_dat_w    = wdata;
    rdata       = '0;
    waited      = 0;
    do begin
      @(posedge clock);
      #1;
      waited++;
    end while (!wb_ack && waited < 8);
    if (!wb_ack) begin
      $display("No ack from the CSR block for index %0d after %0d cycles", adr, waited);
      errors++;
    end else begin
      rdata = wb_dat_r;
      @(posedge clock);
      #1;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input csr_pkg::wb_adr_t adr, input csr_pkg::wb_dat_t data);
    csr_pkg::wb_dat_t unused;
    bus_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input csr_pkg::wb_adr_t adr, output csr_pkg::wb_dat_t data);
    bus_access(1'b0, adr, '0, data);
  endtask

  task automatic check_status();
    csr_pkg::wb_dat_t word;
    wb_read(csr_pkg::wb_adr_t'(`REG_STATUS), word);
    check_level("STATUS level", fifo_pkg::level_t'(model_q.size()), fifo_pkg::level_t'(word));
    check_reg("STATUS", expected_status(), word);
  endtask

  task automatic check_thresholds();
    csr_pkg::wb_dat_t word;
    wb_read(csr_pkg::wb_adr_t'(`REG_LOWER), word);
    check_reg("LOWER", csr_pkg::wb_dat_t'(model_lower), word);
    wb_read(csr_pkg::wb_adr_t'(`REG_UPPER), word);
    check_reg("UPPER", csr_pkg::wb_dat_t'(model_upper), word);
  endtask

  task automatic test_reset();
    csr_pkg::wb_dat_t word;
    check_flag("read_valid", 1'b0, read_valid);
    check_flag("write_ready", 1'b1, write_ready);
    check_status();
    // Reset values straight from the register map
    wb_read(csr_pkg::wb_adr_t'(`REG_LOWER), word);
    check_reg("LOWER", csr_pkg::wb_dat_t'(1), word);
    wb_read(csr_pkg::wb_adr_t'(`REG_UPPER), word);
    check_reg("UPPER", csr_pkg::wb_dat_t'(DEPTH - 1), word);
  endtask

  // Random words with random gaps on both sides
  task automatic test_order(input int count);
    fifo_pkg::data_t word;
    logic            pending;
    logic            wf;
    logic            rf;
    int              written;
    int              drained;
    int              cycles;
    word    = '0;
    pending = 1'b0;
    written = 0;
    drained = 0;
    cycles  = 0;
    while (drained < count) begin
      if (!pending && written < count && ($urandom % 4) != 0) begin
        pending = 1'b1;
        word    = fifo_pkg::data_t'($urandom);
      end
      data_cycle(pending, word, ($urandom % 3) != 0, wf, rf);
      if (wf) begin
        pending = 1'b0;
        written++;
      end
      if (rf) begin
        drained++;
      end
      cycles++;
      // Poll only between words, valid never drops early
      if (!pending && (cycles % 7) == 0) begin
        check_status();
      end
    end
  endtask

  task automatic test_fill();
    fifo_pkg::data_t held;
    logic            pending;
    logic            wf;
    logic            rf;
    repeat (DEPTH) begin
      push_word(fifo_pkg::data_t'($urandom));
    end
    check_flag("write_ready when full", 1'b0, write_ready);
    check_status();
    held = fifo_pkg::data_t'($urandom);
    repeat (3) begin
      data_cycle(1'b1, held, 1'b0, wf, rf);
      // Still full after the edge, held word not taken
      check_flag("write_ready while held", 1'b0, write_ready);
    end
    // Drain while the held word stays on offer
    pending = 1'b1;
    while (model_q.size() != 0 || pending) begin
      data_cycle(pending, held, 1'b1, wf, rf);
      if (wf) begin
        pending = 1'b0;
      end
    end
    check_status();
  endtask

  task automatic test_thresholds();
    model_lower = 3;
    model_upper = 5;
    wb_write(csr_pkg::wb_adr_t'(`REG_LOWER), csr_pkg::wb_dat_t'(model_lower));
    wb_write(csr_pkg::wb_adr_t'(`REG_UPPER), csr_pkg::wb_dat_t'(model_upper));
    check_thresholds();
    // Every level on the way up and back down
    repeat (DEPTH) begin
      check_status();
      push_word(fifo_pkg::data_t'($urandom));
    end
    check_status();
    while (model_q.size() != 0) begin
      pop_word();
      check_status();
    end
  endtask

  task automatic test_flush();
    repeat (5) begin
      push_word(fifo_pkg::data_t'($urandom));
    end
    check_status();
    wb_write(csr_pkg::wb_adr_t'(`REG_CTRL), csr_pkg::wb_dat_t'(1));
    model_q.delete();
    check_flag("read_valid after flush", 1'b0, read_valid);
    check_status();
    // Fresh order after the flush
    repeat (3) begin
      push_word(fifo_pkg::data_t'($urandom));
    end
    check_status();
    repeat (3) begin
      pop_word();
    end
    check_status();
  endtask

  task automatic test_register_map();
    csr_pkg::wb_dat_t word;
    wb_read(csr_pkg::wb_adr_t'(`REG_CTRL), word);
    check_reg("CTRL", '0, word);
    wb_read(csr_pkg::wb_adr_t'(9), word);
    check_reg("unmapped index 9", '0, word);
    wb_write(csr_pkg::wb_adr_t'(9), 32'hffff_ffff);
    check_thresholds();
    check_status();
  endtask

  initial begin
    clock       = 1'b0;
    arst_n      = 1'b0;
    write_data  = '0;
    write_valid = 1'b0;
    read_ready  = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    model_lower = 1;
    model_upper = DEPTH - 1;
    void'($urandom(82));
    repeat (3) @(posedge clock);
    #1;
    arst_n = 1'b1;
    test_reset();
    test_order(ORDER_WORDS);
    test_fill();
    test_thresholds();
    test_flush();
    test_register_map();
    $display("Run complete with %0d check errors and %0d assertion failures",
             errors, dut0.checker0.failures);
    if (errors == 0 && dut0.checker0.failures == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Bound on the whole run
  initial begin
    #(WATCHDOG_CYCLES * CLOCK_PERIOD);
    $display("Watchdog expired after %0d cycles, the tests did not complete",
             WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire
